// File: vlog.f
+incdir+bench
logic/fb_loop_pkg.sv
logic/step_link_if.sv
logic/err_demod.sv
logic/step_integrator.sv
logic/dac_arbiter.sv
logic/fb_loop_top.sv
bench/fb_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the feedback loop testbench with verilator and run it
# exit status is nonzero on a build error or a reported test failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fb_loop_tb -f vlog.f -o fb_loop_sim \
	&& ./obj_dir/fb_loop_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log \
	&& { echo "simulation FAILED"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// File: bench/fb_loop_ref.svh
// ********************
// reference model of demodulation, step integration and output shift
// included inside the feedback loop testbench module
// ********************
`ifndef FB_LOOP_REF_SVH
`define FB_LOOP_REF_SVH

// second half-period sum minus first half-period sum
function automatic longint demod_ref(input int samp [PERIOD_LEN]);
	longint first;
	longint second;
	first = 0;
	second = 0;
	for (int k = 0; k < PERIOD_LEN; k++) begin
		if (k < PERIOD_LEN / 2) begin
			first += samp[k];
		end else begin
			second += samp[k];
		end
	end
	return second - first;
endfunction

// one trigger of the step integrator, window of step_max times 2^shift
function automatic void integrate_ref(inout longint step, inout fb_loop_pkg::sat_state_t sat,
	input longint err, input int step_max, input int shift);
	longint lim;
	longint sum;
	lim = longint'(step_max) <<< shift;
	sum = step + err;
	if (shift == int'(fb_loop_pkg::GAIN_OFF)) begin
		// open loop
		step = 0;
		sat = fb_loop_pkg::SAT_NONE;
	end else if (sat == fb_loop_pkg::SAT_POS) begin
		if (err < 0) begin
			step = sum;
			sat = fb_loop_pkg::SAT_NONE;
		end else begin
			step = lim;
		end
	end else if (sat == fb_loop_pkg::SAT_NEG) begin
		if (err >= 0) begin
			step = sum;
			sat = fb_loop_pkg::SAT_NONE;
		end else begin
			step = -lim;
		end
	end else if (sum > lim) begin
		step = lim;
		sat = fb_loop_pkg::SAT_POS;
	end else if (sum < -lim) begin
		step = -lim;
		sat = fb_loop_pkg::SAT_NEG;
	end else begin
		step = sum;
	end
endfunction

// dac code is the step scaled back down by the gain shift
function automatic logic signed [15:0] code_ref(input longint step, input int shift);
	longint scaled;
	scaled = step >>> shift;
	return scaled[15:0];
endfunction

`endif

// File: bench/fb_loop_tb.sv
// ********************
// testbench for the two-channel feedback loop with a random-delay dac credit model
// every dac word is checked against the reference codes
// ********************
`timescale 1ns/100ps

module fb_loop_tb;

	localparam int N_CHAN = 2;
	localparam int DAC_CREDITS = 4;
	localparam int PERIOD_LEN = 16;
	// the tests take about 9500 cycles, allow twice that
	localparam int MAX_CYCLES = 20000;

	`include "fb_loop_ref.svh"

	logic i_clk;
	logic i_rst_n;
	logic [N_CHAN-1:0] i_adc_valid;
	logic [N_CHAN-1:0][fb_loop_pkg::ADC_W-1:0] i_adc;
	logic [N_CHAN-1:0][fb_loop_pkg::GAIN_W-1:0] i_gain_sel;
	logic [N_CHAN-1:0][fb_loop_pkg::DAC_W-1:0] i_step_max;
	logic i_dac_credit;
	logic o_dac_valid;
	logic [0:0] o_dac_chan;
	logic signed [fb_loop_pkg::DAC_W-1:0] o_dac_code;
	logic [N_CHAN-1:0] o_fb_on;
	logic [N_CHAN-1:0] o_sat_pos;
	logic [N_CHAN-1:0] o_sat_neg;

	// reference state and test settings per channel
	longint step_m [N_CHAN];
	fb_loop_pkg::sat_state_t sat_m [N_CHAN];
	logic signed [15:0] cur_code [N_CHAN];
	logic signed [15:0] prev_code [N_CHAN];
	logic signed [15:0] last_word [N_CHAN];
	logic [fb_loop_pkg::GAIN_W-1:0] gain_nxt [N_CHAN];
	logic [fb_loop_pkg::DAC_W-1:0] smax_nxt [N_CHAN];
	int bias [N_CHAN];
	int word_cnt [N_CHAN];
	logic strict [N_CHAN];
	logic zero_only [N_CHAN];
	logic hold;
	logic hold_nxt;
	logic fair;
	logic have_last;
	int last_chan;
	int hold_base;
	int words_total = 0;
	int credits_ret = 0;
	int errors = 0;
	int cycles = 0;
	int tests_run = 0;
	int tests_failed = 0;
	// credit return ring, indexed by cycle
	int due [8];
	int cslot = 0;
	int owed = 0;

	fb_loop_top #(
		.N_CHAN      (N_CHAN),
		.DAC_CREDITS (DAC_CREDITS),
		.PERIOD_LEN  (PERIOD_LEN)
	) u_dut (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_adc_valid  (i_adc_valid),
		.i_adc        (i_adc),
		.i_gain_sel   (i_gain_sel),
		.i_step_max   (i_step_max),
		.i_dac_credit (i_dac_credit),
		.o_dac_valid  (o_dac_valid),
		.o_dac_chan   (o_dac_chan),
		.o_dac_code   (o_dac_code),
		.o_fb_on      (o_fb_on),
		.o_sat_pos    (o_sat_pos),
		.o_sat_neg    (o_sat_neg)
	);

	initial i_clk = 1'b0;
	always #4 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// dac model, one credit back 1 to 6 cycles after each word
	always @(posedge i_clk) begin
		logic blocked;
		blocked = hold;
		cslot = (cslot + 1) % 8;
		owed = owed + due[cslot];
		due[cslot] = 0;
		if (i_rst_n && o_dac_valid) begin
			due[(cslot + 1 + int'($urandom_range(5, 0))) % 8]++;
		end
		#1;
		if (!blocked && owed > 0) begin
			i_dac_credit = 1'b1;
			owed--;
			credits_ret++;
		end else begin
			i_dac_credit = 1'b0;
		end
	end

	// compare every dac word with the reference
	always @(posedge i_clk) begin
		int c;
		if (i_rst_n && o_dac_valid) begin
			c = int'(o_dac_chan);
			words_total++;
			word_cnt[c]++;
			last_word[c] = o_dac_code;
			if (words_total > DAC_CREDITS + credits_ret) begin
				$display("dac word %0d sent with only %0d credits returned",
					words_total, credits_ret);
				errors++;
			end
			if (zero_only[c] && o_dac_code != 16'sd0) begin
				$display("error o_dac_code ch%0d: got %h, expected 0000", c, o_dac_code);
				errors++;
			end else if (strict[c] && o_dac_code != cur_code[c]) begin
				$display("error o_dac_code ch%0d: got %h, expected %h",
					c, o_dac_code, cur_code[c]);
				errors++;
			end else if (o_dac_code != cur_code[c] && o_dac_code != prev_code[c]) begin
				$display("error o_dac_code ch%0d: got %h, expected %h or %h",
					c, o_dac_code, cur_code[c], prev_code[c]);
				errors++;
			end
			strict[c] = 1'b0;
			if (fair && have_last && c == last_chan) begin
				$display("channel %0d was granted twice in a row", c);
				errors++;
			end
			last_chan = c;
			have_last = 1'b1;
		end
	end

	// drive n back-to-back periods on all channels and advance the reference
	task automatic run_periods(input int n);
		int row [PERIOD_LEN];
		int samp [N_CHAN][PERIOD_LEN];
		longint err [N_CHAN];
		for (int p = 0; p < n; p++) begin
			for (int c = 0; c < N_CHAN; c++) begin
				for (int k = 0; k < PERIOD_LEN; k++) begin
					row[k] = ((k < PERIOD_LEN / 2) ? -bias[c] : bias[c])
						+ int'($urandom_range(255, 0)) - 128;
					samp[c][k] = row[k];
				end
				err[c] = demod_ref(row);
			end
			for (int k = 0; k < PERIOD_LEN; k++) begin
				for (int c = 0; c < N_CHAN; c++) begin
					i_adc[c] = samp[c][k][fb_loop_pkg::ADC_W-1:0];
					// settings change well away from the trigger
					if (k == 4) begin
						i_gain_sel[c] = gain_nxt[c];
						i_step_max[c] = smax_nxt[c];
					end
				end
				i_adc_valid = '1;
				if (k == 8 && hold != hold_nxt) begin
					if (hold_nxt) begin
						hold_base = words_total;
					end else begin
						if (words_total - hold_base > DAC_CREDITS) begin
							$display("%0d words went out while credits were withheld",
								words_total - hold_base);
							errors++;
						end
						for (int c = 0; c < N_CHAN; c++) begin
							strict[c] = 1'b1;
						end
					end
					hold = hold_nxt;
				end
				@(posedge i_clk);
				#1;
			end
			for (int c = 0; c < N_CHAN; c++) begin
				integrate_ref(step_m[c], sat_m[c], err[c], int'(smax_nxt[c]), int'(gain_nxt[c]));
				prev_code[c] = cur_code[c];
				cur_code[c] = code_ref(step_m[c], int'(gain_nxt[c]));
			end
		end
		i_adc_valid = '0;
	endtask

	// wait until each channel has delivered one more word
	task automatic wait_words();
		int n0;
		int n1;
		n0 = word_cnt[0];
		n1 = word_cnt[1];
		while (word_cnt[0] == n0 || word_cnt[1] == n1) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err0);
		end
	endtask

	initial begin
		int e0;
		void'($urandom(32'hcaeb));
		i_rst_n = 1'b0;
		i_adc_valid = '0;
		i_adc = '0;
		i_dac_credit = 1'b0;
		hold = 1'b0;
		hold_nxt = 1'b0;
		fair = 1'b0;
		have_last = 1'b0;
		last_chan = 0;
		hold_base = 0;
		for (int c = 0; c < N_CHAN; c++) begin
			i_gain_sel[c] = fb_loop_pkg::GAIN_RST;
			i_step_max[c] = fb_loop_pkg::STEP_MAX_RST;
			gain_nxt[c] = fb_loop_pkg::GAIN_RST;
			smax_nxt[c] = fb_loop_pkg::STEP_MAX_RST;
			step_m[c] = 0;
			sat_m[c] = fb_loop_pkg::SAT_NONE;
			cur_code[c] = '0;
			prev_code[c] = '0;
			last_word[c] = '0;
			bias[c] = 0;
			word_cnt[c] = 0;
			strict[c] = 1'b0;
			zero_only[c] = 1'b0;
		end
		for (int s = 0; s < 8; s++) begin
			due[s] = 0;
		end
		repeat (5) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(posedge i_clk);
		#1;

		e0 = errors;
		run_periods(500);
		wait_words();
		if (word_cnt[0] < 400 || word_cnt[1] < 400) begin
			$display("too few dac words during normal integration");
			errors++;
		end
		finish_test("normal integration", e0);

		e0 = errors;
		bias[0] = 1250;
		run_periods(12);
		wait_words();
		if (!o_sat_pos[0]) begin
			$display("error o_sat_pos[0]: got %h, expected 1", o_sat_pos[0]);
			errors++;
		end
		if (last_word[0] != 16'sd5000) begin
			$display("error o_dac_code ch0: got %h, expected %h", last_word[0], 16'sd5000);
			errors++;
		end
		bias[0] = -300;
		run_periods(2);
		wait_words();
		if (o_sat_pos[0]) begin
			$display("error o_sat_pos[0]: got %h, expected 0", o_sat_pos[0]);
			errors++;
		end
		bias[0] = 0;
		finish_test("positive saturation and release", e0);

		e0 = errors;
		smax_nxt[1] = 16'd3000;
		bias[1] = -1250;
		run_periods(12);
		wait_words();
		if (!o_sat_neg[1]) begin
			$display("error o_sat_neg[1]: got %h, expected 1", o_sat_neg[1]);
			errors++;
		end
		if (last_word[1] != -16'sd3000) begin
			$display("error o_dac_code ch1: got %h, expected %h", last_word[1], -16'sd3000);
			errors++;
		end
		bias[1] = 300;
		run_periods(2);
		wait_words();
		if (o_sat_neg[1]) begin
			$display("error o_sat_neg[1]: got %h, expected 0", o_sat_neg[1]);
			errors++;
		end
		bias[1] = 0;
		finish_test("negative saturation and release", e0);

		e0 = errors;
		gain_nxt[1] = fb_loop_pkg::GAIN_OFF;
		run_periods(1);
		zero_only[1] = 1'b1;
		run_periods(2);
		wait_words();
		if (o_fb_on[1]) begin
			$display("error o_fb_on[1]: got %h, expected 0", o_fb_on[1]);
			errors++;
		end
		zero_only[1] = 1'b0;
		gain_nxt[1] = fb_loop_pkg::GAIN_RST;
		run_periods(3);
		wait_words();
		if (!o_fb_on[1]) begin
			$display("error o_fb_on[1]: got %h, expected 1", o_fb_on[1]);
			errors++;
		end
		finish_test("loop disable and restart", e0);

		e0 = errors;
		hold_nxt = 1'b1;
		run_periods(6);
		hold_nxt = 1'b0;
		run_periods(3);
		wait_words();
		if (strict[0] || strict[1]) begin
			$display("no dac word followed the return of credits");
			errors++;
		end
		finish_test("credit back-pressure", e0);

		e0 = errors;
		have_last = 1'b0;
		fair = 1'b1;
		run_periods(40);
		wait_words();
		fair = 1'b0;
		finish_test("arbitration fairness", e0);

		$display("tests run %0d, failed %0d, dac words %0d, errors %0d",
			tests_run, tests_failed, words_total, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: logic/fb_loop_top.sv
// ********************
// closed-loop feedback path, N_CHAN demodulator and integrator channels
// sharing one credit-controlled dac bus
// ********************
`timescale 1ns/100ps

module fb_loop_top #(
	parameter int N_CHAN      = 2,
	parameter int DAC_CREDITS = 4,
	parameter int PERIOD_LEN  = 16
) (
	input  logic                                             i_clk,
	input  logic                                             i_rst_n,
	// adc samples per channel
	input  logic [N_CHAN-1:0]                                i_adc_valid,
	input  logic [N_CHAN-1:0][fb_loop_pkg::ADC_W-1:0]        i_adc,
	// loop settings per channel
	input  logic [N_CHAN-1:0][fb_loop_pkg::GAIN_W-1:0]       i_gain_sel,
	input  logic [N_CHAN-1:0][fb_loop_pkg::DAC_W-1:0]        i_step_max,
	// dac bus
	input  logic                                             i_dac_credit,
	output logic                                             o_dac_valid,
	output logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0]   o_dac_chan,
	output logic signed [fb_loop_pkg::DAC_W-1:0]             o_dac_code,
	// status
	output logic [N_CHAN-1:0]                                o_fb_on,
	output logic [N_CHAN-1:0]                                o_sat_pos,
	output logic [N_CHAN-1:0]                                o_sat_neg
);

	step_link_if u_link [N_CHAN] ();

	for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
		logic trig;
		logic signed [fb_loop_pkg::ERR_W-1:0] err;

		err_demod #(
			.PERIOD_LEN (PERIOD_LEN)
		) u_demod (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_adc_valid (i_adc_valid[c]),
			.i_adc       ($signed(i_adc[c])),
			.o_trig      (trig),
			.o_err       (err)
		);

		step_integrator u_integ (
			.i_clk      (i_clk),
			.i_rst_n    (i_rst_n),
			.i_trig     (trig),
			.i_err      (err),
			.i_gain_sel (i_gain_sel[c]),
			.i_step_max (i_step_max[c]),
			.o_link     (u_link[c])
		);

		// status straight from the link
		assign o_fb_on[c]   = u_link[c].fb_on;
		assign o_sat_pos[c] = (u_link[c].sat == fb_loop_pkg::SAT_POS);
		assign o_sat_neg[c] = (u_link[c].sat == fb_loop_pkg::SAT_NEG);
	end

	dac_arbiter #(
		.N_CHAN      (N_CHAN),
		.DAC_CREDITS (DAC_CREDITS)
	) u_arb (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_link       (u_link),
		.i_dac_credit (i_dac_credit),
		.o_dac_valid  (o_dac_valid),
		.o_dac_chan   (o_dac_chan),
		.o_dac_code   (o_dac_code)
	);

endmodule

// File: logic/dac_arbiter.sv
// ********************
// round-robin arbiter for the shared dac bus with credit flow control
// keeps only the newest pending word per channel
// ********************
`timescale 1ns/100ps

module dac_arbiter #(
	parameter int N_CHAN      = 2,
	parameter int DAC_CREDITS = 4
) (
	input  logic                                      i_clk,
	input  logic                                      i_rst_n,
	step_link_if.sink                                 i_link [N_CHAN],
	input  logic                                      i_dac_credit,
	output logic                                      o_dac_valid,
	output logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0] o_dac_chan,
	output logic signed [fb_loop_pkg::DAC_W-1:0]      o_dac_code
);

	localparam int CHAN_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
	localparam int CRED_W = $clog2(DAC_CREDITS + 1);

	logic link_valid [N_CHAN];
	logic signed [fb_loop_pkg::DAC_W-1:0] link_code [N_CHAN];
	logic signed [fb_loop_pkg::DAC_W-1:0] word_q [N_CHAN];
	logic signed [fb_loop_pkg::DAC_W-1:0] eff_code [N_CHAN];
	logic [N_CHAN-1:0] pend_q;
	logic [N_CHAN-1:0] eff_pend;
	// last channel granted
	logic [CHAN_W-1:0] rr_ptr;
	logic [CRED_W-1:0] credit;
	logic [CHAN_W-1:0] gnt;
	logic found;
	logic send;

	// a word arriving this cycle counts as pending already
	for (genvar c = 0; c < N_CHAN; c++) begin : g_link
		assign link_valid[c] = i_link[c].valid;
		assign link_code[c]  = i_link[c].code;
		assign eff_pend[c]   = pend_q[c] | link_valid[c];
		assign eff_code[c]   = link_valid[c] ? link_code[c] : word_q[c];
	end

	// first pending channel after the last grantee
	always_comb begin
		int idx;
		found = 1'b0;
		gnt   = rr_ptr;
		for (int off = 1; off <= N_CHAN; off++) begin
			idx = (int'(rr_ptr) + off) % N_CHAN;
			if (!found && eff_pend[idx]) begin
				found = 1'b1;
				gnt   = CHAN_W'(idx);
			end
		end
	end

	assign send = found && (credit != '0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pend_q      <= '0;
			rr_ptr      <= CHAN_W'(N_CHAN - 1);
			credit      <= CRED_W'(DAC_CREDITS);
			o_dac_valid <= 1'b0;
		end else begin
			o_dac_valid <= send;
			for (int c = 0; c < N_CHAN; c++) begin
				pend_q[c] <= eff_pend[c] && !(send && gnt == CHAN_W'(c));
			end
			if (send) begin
				rr_ptr <= gnt;
			end
			// word out and credit back together leave the count unchanged
			if (send && !i_dac_credit) begin
				credit <= credit - 1'b1;
			end else if (!send && i_dac_credit) begin
				credit <= credit + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int c = 0; c < N_CHAN; c++) begin
			if (link_valid[c]) begin
				word_q[c] <= link_code[c];
			end
		end
		if (send) begin
			o_dac_chan <= gnt;
			o_dac_code <= eff_code[gnt];
		end
	end

endmodule

// File: logic/step_integrator.sv
// ********************
// feedback step integrator with gain shift and a saturating window
// one update per demodulator trigger, result goes out on a step link
// ********************
`timescale 1ns/100ps

module step_integrator (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_trig,
	input  logic signed [fb_loop_pkg::ERR_W-1:0]  i_err,
	input  logic [fb_loop_pkg::GAIN_W-1:0]        i_gain_sel,
	input  logic [fb_loop_pkg::DAC_W-1:0]         i_step_max,
	step_link_if.source                           o_link
);

	localparam int ERR_W = fb_loop_pkg::ERR_W;
	localparam int DAC_W = fb_loop_pkg::DAC_W;

	logic [fb_loop_pkg::GAIN_W-1:0] shift_q;
	logic [DAC_W-1:0] step_max_q;
	logic signed [ERR_W-1:0] step;
	fb_loop_pkg::sat_state_t sat;
	logic valid_q;
	logic fb_on;

	// window limits in step units
	logic signed [ERR_W-1:0] lim_pos;
	logic signed [ERR_W-1:0] lim_neg;
	// one extra bit so the window test cannot wrap
	logic signed [ERR_W:0] sum;
	logic signed [ERR_W-1:0] code_full;

	assign fb_on = (shift_q != fb_loop_pkg::GAIN_OFF);
	assign lim_pos = $signed({{(ERR_W - DAC_W){1'b0}}, step_max_q}) <<< shift_q;
	assign lim_neg = -lim_pos;
	assign sum = {step[ERR_W-1], step} + {i_err[ERR_W-1], i_err};
	assign code_full = step >>> shift_q;

	// loop settings, retimed
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_q    <= fb_loop_pkg::GAIN_RST;
			step_max_q <= fb_loop_pkg::STEP_MAX_RST;
		end else begin
			shift_q    <= i_gain_sel;
			step_max_q <= i_step_max;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			step <= '0;
			sat  <= fb_loop_pkg::SAT_NONE;
		end else if (!fb_on) begin
			// open loop, hold the step at zero
			step <= '0;
			sat  <= fb_loop_pkg::SAT_NONE;
		end else if (i_trig) begin
			case (sat)
				fb_loop_pkg::SAT_NONE: begin
					if (sum > lim_pos) begin
						step <= lim_pos;
						sat  <= fb_loop_pkg::SAT_POS;
					end else if (sum < lim_neg) begin
						step <= lim_neg;
						sat  <= fb_loop_pkg::SAT_NEG;
					end else begin
						step <= sum[ERR_W-1:0];
					end
				end
				fb_loop_pkg::SAT_POS: begin
					// release only on a negative error
					if (i_err[ERR_W-1]) begin
						step <= sum[ERR_W-1:0];
						sat  <= fb_loop_pkg::SAT_NONE;
					end else begin
						step <= lim_pos;
					end
				end
				fb_loop_pkg::SAT_NEG: begin
					if (!i_err[ERR_W-1]) begin
						step <= sum[ERR_W-1:0];
						sat  <= fb_loop_pkg::SAT_NONE;
					end else begin
						step <= lim_neg;
					end
				end
				default: begin
					sat <= fb_loop_pkg::SAT_NONE;
				end
			endcase
		end
	end

	// new code is visible the cycle after the trigger
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_trig;
		end
	end

	assign o_link.valid = valid_q;
	assign o_link.code  = code_full[DAC_W-1:0];
	assign o_link.sat   = sat;
	assign o_link.fb_on = fb_on;

endmodule

// File: logic/err_demod.sv
// ********************
// square-wave demodulator, second half-period sum minus first half-period sum
// one error word and trigger pulse per PERIOD_LEN valid samples
// ********************
`timescale 1ns/100ps

module err_demod #(
	parameter int PERIOD_LEN = 16
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_adc_valid,
	input  logic signed [fb_loop_pkg::ADC_W-1:0]  i_adc,
	output logic                                  o_trig,
	output logic signed [fb_loop_pkg::ERR_W-1:0]  o_err
);

	localparam int HALF  = PERIOD_LEN / 2;
	localparam int CNT_W = (PERIOD_LEN > 2) ? $clog2(PERIOD_LEN) : 1;

	// sample index within the period
	logic [CNT_W-1:0] cnt;
	// first and second half sums
	logic signed [fb_loop_pkg::ERR_W-1:0] sum_a;
	logic signed [fb_loop_pkg::ERR_W-1:0] sum_b;
	logic last;

	assign last = (cnt == CNT_W'(PERIOD_LEN - 1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt    <= '0;
			sum_a  <= '0;
			sum_b  <= '0;
			o_trig <= 1'b0;
		end else begin
			o_trig <= i_adc_valid && last;
			if (i_adc_valid) begin
				if (last) begin
					// period done, start fresh
					cnt   <= '0;
					sum_a <= '0;
					sum_b <= '0;
				end else begin
					cnt <= cnt + 1'b1;
					if (cnt < HALF) begin
						sum_a <= sum_a + i_adc;
					end else begin
						sum_b <= sum_b + i_adc;
					end
				end
			end
		end
	end

	// last sample belongs to the second half, fold it in here
	always_ff @(posedge i_clk) begin
		if (i_adc_valid && last) begin
			o_err <= sum_b + i_adc - sum_a;
		end
	end

endmodule

// File: logic/step_link_if.sv
// ********************
// one channel's step updates from its integrator to the dac arbiter
// no back-pressure, the arbiter keeps only the newest word
// ********************
`timescale 1ns/100ps

interface step_link_if;

	// one-cycle pulse per new step
	logic valid;
	// dac code, meaningful with valid
	logic signed [fb_loop_pkg::DAC_W-1:0] code;
	// saturation state of the integrator
	fb_loop_pkg::sat_state_t sat;
	// high while the loop is closed
	logic fb_on;

	modport source (
		output valid,
		output code,
		output sat,
		output fb_on
	);

	modport sink (
		input valid,
		input code,
		input sat,
		input fb_on
	);

endinterface

// File: logic/fb_loop_pkg.sv
// ********************
// shared widths, reset values and saturation state type for the feedback loop
// use by scoped names, e.g. fb_loop_pkg::ERR_W
// ********************

package fb_loop_pkg;

	// adc sample width
	localparam int ADC_W = 14;

	// error and integrator step words, signed
	localparam int ERR_W = 32;

	// dac code width, signed
	localparam int DAC_W = 16;

	// gain select width
	localparam int GAIN_W = 4;

	// gain select value that opens the loop
	localparam logic [GAIN_W-1:0] GAIN_OFF = 4'd15;

	// gain shift loaded at reset
	localparam logic [GAIN_W-1:0] GAIN_RST = 4'd5;

	// step window half-width loaded at reset
	localparam logic [DAC_W-1:0] STEP_MAX_RST = 16'd5000;

	// integrator saturation state
	// held until the error sign turns back into the window
	typedef enum logic [1:0] {
		SAT_NONE = 2'd0,
		SAT_POS  = 2'd1,
		SAT_NEG  = 2'd2
	} sat_state_t;

endpackage
